//--- src/phold_pkg.sv
`default_nettype none

package phold_pkg;

   // ----------------------------------------------------------------------
   // Widths with a meaning
   // ----------------------------------------------------------------------

   // Virtual time, used for end time, LVT and GVT
   typedef logic [15:0] vtime_t;
   // Per-LP timestamp increment
   typedef logic [7:0]  stride_t;
   // Event and cycle totals
   typedef logic [31:0] count_t;
   // AEG and CSR data word
   typedef logic [63:0] aeg_data_t;
   // Index as sent on the dispatch port
   typedef logic [17:0] aeg_idx_t;

   // ----------------------------------------------------------------------
   // AEG map
   // ----------------------------------------------------------------------

   localparam int NUM_AEG          = 8;
   localparam int AEG_SIM_END      = 0;
   localparam int AEG_STRIDE0      = 1;
   localparam int AEG_STRIDE1      = 2;
   // Bit 0 enables LP 0, bit 1 enables LP 1
   localparam int AEG_LP_MASK      = 3;
   // Index 4 is scratch, results start at 5
   localparam int AEG_GVT          = 5;
   localparam int AEG_TOTAL_CYCLES = 6;
   localparam int AEG_TOTAL_EVENTS = 7;

   // CSR debug addresses
   localparam logic [15:0] CSR_STATUS = 16'h0000;
   localparam logic [15:0] CSR_GVT    = 16'h0001;

   // Run state, encoding is visible through CSR_STATUS
   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      RUNNING  = 2'd1,
      FINISHED = 2'd2
   } run_state_t;

endpackage

`default_nettype wire

//--- src/lp_event_core.sv
`default_nettype none

module lp_event_core #(
   parameter phold_pkg::vtime_t VTIME_MAX = '1
) (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 run,
   input  wire                 enable,
   input  phold_pkg::stride_t  stride,
   input  phold_pkg::vtime_t   sim_end,
   output phold_pkg::vtime_t   lvt,
   output phold_pkg::count_t   event_count,
   output logic                done
);

   import phold_pkg::*;

   // Timestamp of the next self-scheduled event
   vtime_t lvt_q;
   count_t events_q;
   logic   pending;

   // Event still due before the end time
   assign pending = enable && (lvt_q < sim_end);

   // ----------------------------------------------------------------------
   // Event processing, one event per run cycle
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset || !run) begin
         // Cleared between runs so the next run starts at time zero
         lvt_q    <= '0;
         events_q <= '0;
      end else if (pending) begin
         // Process event, reschedule itself one stride later
         lvt_q    <= lvt_q + vtime_t'(stride);
         events_q <= events_q + 1'b1;
      end
   end

   // Disabled LP has no pending events
   assign lvt         = enable ? lvt_q : VTIME_MAX;
   assign event_count = events_q;
   // Done once past the end time, or never enabled
   assign done        = !pending;

endmodule

`default_nettype wire

//--- src/gvt_reduce.sv
`default_nettype none

module gvt_reduce #(
   parameter phold_pkg::vtime_t VTIME_MAX = '1
) (
   input  wire                clk,
   input  wire                reset,
   input  wire                run,
   input  phold_pkg::vtime_t  lvt0,
   input  phold_pkg::vtime_t  lvt1,
   input  phold_pkg::count_t  event_count0,
   input  phold_pkg::count_t  event_count1,
   input  wire                done0,
   input  wire                done1,
   output phold_pkg::vtime_t  gvt,
   output logic               finished,
   output phold_pkg::count_t  total_events,
   output phold_pkg::count_t  total_cycles
);

   import phold_pkg::*;

   // Run cycles seen before the current one
   count_t cycle_cnt;
   // End of run already reported for this run
   logic   found;
   logic   all_done;
   logic   end_now;
   vtime_t lvt_min;

   assign all_done = done0 && done1;
   // First run cycle with every LP done
   assign end_now  = run && all_done && !found;
   assign lvt_min  = (lvt0 < lvt1) ? lvt0 : lvt1;

   // ----------------------------------------------------------------------
   // Run cycle count and end detection
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset || !run) begin
         cycle_cnt <= '0;
         found     <= 1'b0;
         finished  <= 1'b0;
      end else begin
         if (!found)
            cycle_cnt <= cycle_cnt + 1'b1;
         found    <= found || all_done;
         // Single pulse, the found flag blocks any repeat
         finished <= end_now;
      end
   end

   // ----------------------------------------------------------------------
   // Result registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         gvt          <= VTIME_MAX;
         total_events <= '0;
         total_cycles <= '0;
      end else begin
         // Old results dropped on the first cycle of a new run
         if (run && (cycle_cnt == '0) && !found) begin
            gvt          <= VTIME_MAX;
            total_events <= '0;
            total_cycles <= '0;
         end
         // Snapshot at the end, includes the current cycle
         if (end_now) begin
            gvt          <= lvt_min;
            total_events <= event_count0 + event_count1;
            total_cycles <= cycle_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/pers_dispatch.sv
`default_nettype none

module pers_dispatch (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    disp_inst_vld,
   input  wire  [4:0]             disp_inst,
   input  phold_pkg::aeg_idx_t    disp_aeg_idx,
   input  wire                    disp_aeg_rd,
   input  wire                    disp_aeg_wr,
   input  phold_pkg::aeg_data_t   disp_aeg_wr_data,
   input  wire                    csr_rd_vld,
   input  wire  [15:0]            csr_address,
   input  phold_pkg::vtime_t      gvt,
   input  wire                    finished,
   input  phold_pkg::count_t      total_events,
   input  phold_pkg::count_t      total_cycles,
   output logic [15:0]            disp_exception,
   output logic                   disp_idle,
   output logic                   disp_stall,
   output logic                   disp_rtn_data_vld,
   output phold_pkg::aeg_data_t   disp_rtn_data,
   output logic                   csr_rd_ack,
   output phold_pkg::aeg_data_t   csr_rd_data,
   output logic                   run,
   output phold_pkg::vtime_t      sim_end,
   output phold_pkg::stride_t     stride0,
   output phold_pkg::stride_t     stride1,
   output logic [1:0]             lp_mask
);

   import phold_pkg::*;

   // Low index bits that select one AEG
   localparam int AEG_SEL_W = $clog2(NUM_AEG);

   aeg_data_t            aeg [NUM_AEG];
   logic                 idx_ok;
   logic [AEG_SEL_W-1:0] idx_sel;
   logic                 err_unimpl;
   logic                 err_aegidx;
   logic                 start_now;
   logic                 start_q;
   run_state_t           state;

   // Indices 8 and up do not exist
   assign idx_ok  = disp_aeg_idx < aeg_idx_t'(NUM_AEG);
   assign idx_sel = disp_aeg_idx[AEG_SEL_W-1:0];

   // ----------------------------------------------------------------------
   // AEG register file
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_AEG; i++)
            aeg[i] <= '0;
      end else begin
         // Results land at the end of a run
         if (finished) begin
            aeg[AEG_GVT]          <= aeg_data_t'(gvt);
            aeg[AEG_TOTAL_CYCLES] <= aeg_data_t'(total_cycles);
            aeg[AEG_TOTAL_EVENTS] <= aeg_data_t'(total_events);
         end
         // Host write comes last so it wins over the capture
         if (disp_aeg_wr && idx_ok)
            aeg[idx_sel] <= disp_aeg_wr_data;
      end
   end

   // Run setup straight from the AEGs
   assign sim_end = aeg[AEG_SIM_END][$bits(vtime_t)-1:0];
   assign stride0 = aeg[AEG_STRIDE0][$bits(stride_t)-1:0];
   assign stride1 = aeg[AEG_STRIDE1][$bits(stride_t)-1:0];
   assign lp_mask = aeg[AEG_LP_MASK][1:0];

   // ----------------------------------------------------------------------
   // AEG reads and exceptions, one cycle after the request
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         disp_rtn_data_vld <= 1'b0;
         err_unimpl        <= 1'b0;
         err_aegidx        <= 1'b0;
      end else begin
         disp_rtn_data_vld <= disp_aeg_rd;
         // Only instruction 0 is implemented
         err_unimpl        <= disp_inst_vld && (disp_inst != 5'd0);
         err_aegidx        <= (disp_aeg_rd || disp_aeg_wr) && !idx_ok;
      end
   end

   // Read data, zero for a bad index
   always_ff @(posedge clk) begin
      disp_rtn_data <= idx_ok ? aeg[idx_sel] : '0;
   end

   assign disp_exception = {14'd0, err_aegidx, err_unimpl};

   // ----------------------------------------------------------------------
   // Run control FSM
   // ----------------------------------------------------------------------

   // Start only from a quiet IDLE, anything else is dropped
   assign start_now = disp_inst_vld && (disp_inst == 5'd0)
                      && (state == IDLE) && !start_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         start_q <= 1'b0;
         state   <= IDLE;
      end else begin
         start_q <= start_now;
         case (state)
            IDLE:     if (start_q) state <= RUNNING;
            RUNNING:  if (finished) state <= FINISHED;
            // One cycle to let the results settle into the AEGs
            FINISHED: state <= IDLE;
            default:  state <= IDLE;
         endcase
      end
   end

   assign run        = (state == RUNNING);
   // Host holds off from the start request until back in IDLE
   assign disp_stall = (state != IDLE) || start_now || start_q;
   assign disp_idle  = (state == IDLE) && !start_q;

   // ----------------------------------------------------------------------
   // CSR debug reads
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset)
         csr_rd_ack <= 1'b0;
      else
         csr_rd_ack <= csr_rd_vld;
   end

   always_ff @(posedge clk) begin
      case (csr_address)
         CSR_STATUS: csr_rd_data <= aeg_data_t'(state);
         CSR_GVT:    csr_rd_data <= aeg[AEG_GVT];
         // Unknown address reads zero
         default:    csr_rd_data <= '0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/phold_pers_top.sv
`default_nettype none

module phold_pers_top #(
   parameter phold_pkg::vtime_t VTIME_MAX = '1
) (
   input  wire                    clk,
   input  wire                    reset,
   // Dispatch port
   input  wire                    disp_inst_vld,
   input  wire  [4:0]             disp_inst,
   input  phold_pkg::aeg_idx_t    disp_aeg_idx,
   input  wire                    disp_aeg_rd,
   input  wire                    disp_aeg_wr,
   input  phold_pkg::aeg_data_t   disp_aeg_wr_data,
   output wire  [15:0]            disp_exception,
   output wire                    disp_idle,
   output wire                    disp_stall,
   output wire                    disp_rtn_data_vld,
   output phold_pkg::aeg_data_t   disp_rtn_data,
   // CSR debug port
   input  wire                    csr_rd_vld,
   input  wire  [15:0]            csr_address,
   output wire                    csr_rd_ack,
   output phold_pkg::aeg_data_t   csr_rd_data
);

   import phold_pkg::*;

   // Run setup towards the cores
   logic       run;
   vtime_t     sim_end;
   stride_t    stride0;
   stride_t    stride1;
   logic [1:0] lp_mask;
   // Per-LP status
   vtime_t     lvt0;
   vtime_t     lvt1;
   count_t     event_count0;
   count_t     event_count1;
   logic       done0;
   logic       done1;
   // Combined results
   vtime_t     gvt;
   logic       finished;
   count_t     total_events;
   count_t     total_cycles;

   pers_dispatch u_dispatch (
      .clk               (clk),
      .reset             (reset),
      .disp_inst_vld     (disp_inst_vld),
      .disp_inst         (disp_inst),
      .disp_aeg_idx      (disp_aeg_idx),
      .disp_aeg_rd       (disp_aeg_rd),
      .disp_aeg_wr       (disp_aeg_wr),
      .disp_aeg_wr_data  (disp_aeg_wr_data),
      .csr_rd_vld        (csr_rd_vld),
      .csr_address       (csr_address),
      .gvt               (gvt),
      .finished          (finished),
      .total_events      (total_events),
      .total_cycles      (total_cycles),
      .disp_exception    (disp_exception),
      .disp_idle         (disp_idle),
      .disp_stall        (disp_stall),
      .disp_rtn_data_vld (disp_rtn_data_vld),
      .disp_rtn_data     (disp_rtn_data),
      .csr_rd_ack        (csr_rd_ack),
      .csr_rd_data       (csr_rd_data),
      .run               (run),
      .sim_end           (sim_end),
      .stride0           (stride0),
      .stride1           (stride1),
      .lp_mask           (lp_mask)
   );

   // Two LPs side by side
   lp_event_core #(.VTIME_MAX(VTIME_MAX)) lp0 (
      .clk         (clk),
      .reset       (reset),
      .run         (run),
      .enable      (lp_mask[0]),
      .stride      (stride0),
      .sim_end     (sim_end),
      .lvt         (lvt0),
      .event_count (event_count0),
      .done        (done0)
   );

   lp_event_core #(.VTIME_MAX(VTIME_MAX)) lp1 (
      .clk         (clk),
      .reset       (reset),
      .run         (run),
      .enable      (lp_mask[1]),
      .stride      (stride1),
      .sim_end     (sim_end),
      .lvt         (lvt1),
      .event_count (event_count1),
      .done        (done1)
   );

   gvt_reduce #(.VTIME_MAX(VTIME_MAX)) u_gvt_reduce (
      .clk          (clk),
      .reset        (reset),
      .run          (run),
      .lvt0         (lvt0),
      .lvt1         (lvt1),
      .event_count0 (event_count0),
      .event_count1 (event_count1),
      .done0        (done0),
      .done1        (done1),
      .gvt          (gvt),
      .finished     (finished),
      .total_events (total_events),
      .total_cycles (total_cycles)
   );

endmodule

`default_nettype wire

//--- verif/phold_pers_assertions.sv
`default_nettype none

module phold_pers_assertions (
   input wire clk,
   input wire reset,
   input wire run,
   input wire disp_stall,
   input wire finished,
   input wire csr_rd_vld,
   input wire csr_rd_ack,
   input wire disp_aeg_rd,
   input wire disp_rtn_data_vld
);

   // ----------------------------------------------------------------------
   // Dispatch and reducer timing
   // ----------------------------------------------------------------------

   // Host must be held off for the whole run
   stall_while_running: assert property (@(posedge clk) disable iff (reset)
      run |-> disp_stall)
      else $error("disp_stall low while run is high");

   // End of run is a single pulse
   finished_single_pulse: assert property (@(posedge clk) disable iff (reset)
      finished |=> !finished)
      else $error("finished high for more than one cycle");

   // CSR ack exactly one cycle after the request
   csr_ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
      csr_rd_ack == $past(csr_rd_vld))
      else $error("csr_rd_ack not one cycle after csr_rd_vld");

   // AEG read data valid one cycle after the strobe
   rtn_vld_one_cycle: assert property (@(posedge clk) disable iff (reset)
      disp_rtn_data_vld == $past(disp_aeg_rd))
      else $error("disp_rtn_data_vld not one cycle after disp_aeg_rd");

endmodule

// Dispatch side sees every signal, the reducer's finished pulse included
bind pers_dispatch phold_pers_assertions u_dispatch_sva (
   .clk               (clk),
   .reset             (reset),
   .run               (run),
   .disp_stall        (disp_stall),
   .finished          (finished),
   .csr_rd_vld        (csr_rd_vld),
   .csr_rd_ack        (csr_rd_ack),
   .disp_aeg_rd       (disp_aeg_rd),
   .disp_rtn_data_vld (disp_rtn_data_vld)
);

`default_nettype wire

//--- verif/tb_phold_pers.sv
`default_nettype none

module tb_phold_pers;

   import phold_pkg::*;

   logic        clk;
   logic        reset;
   logic        disp_inst_vld;
   logic [4:0]  disp_inst;
   aeg_idx_t    disp_aeg_idx;
   logic        disp_aeg_rd;
   logic        disp_aeg_wr;
   aeg_data_t   disp_aeg_wr_data;
   logic        csr_rd_vld;
   logic [15:0] csr_address;
   logic [15:0] disp_exception;
   logic        disp_idle;
   logic        disp_stall;
   logic        disp_rtn_data_vld;
   aeg_data_t   disp_rtn_data;
   logic        csr_rd_ack;
   aeg_data_t   csr_rd_data;

   // Parsed stimulus records
   byte         op_q [$];
   aeg_data_t   arg_a_q [$];
   aeg_data_t   arg_b_q [$];
   int          fd;
   int          rc;
   string       line;
   aeg_data_t   arg_a;
   aeg_data_t   arg_b;
   // Watchdog
   int          cycle_sum = 0;
   int          cycle_limit = 0;
   int          cycle_count = 0;
   // Exception word seen after the last request
   logic [15:0] last_exc;

   phold_pers_top #(.VTIME_MAX('1)) DUT (
      .clk               (clk),
      .reset             (reset),
      .disp_inst_vld     (disp_inst_vld),
      .disp_inst         (disp_inst),
      .disp_aeg_idx      (disp_aeg_idx),
      .disp_aeg_rd       (disp_aeg_rd),
      .disp_aeg_wr       (disp_aeg_wr),
      .disp_aeg_wr_data  (disp_aeg_wr_data),
      .disp_exception    (disp_exception),
      .disp_idle         (disp_idle),
      .disp_stall        (disp_stall),
      .disp_rtn_data_vld (disp_rtn_data_vld),
      .disp_rtn_data     (disp_rtn_data),
      .csr_rd_vld        (csr_rd_vld),
      .csr_address       (csr_address),
      .csr_rd_ack        (csr_rd_ack),
      .csr_rd_data       (csr_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Failure handling
   // ----------------------------------------------------------------------
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check(input string name, input logic [63:0] exp_val,
                        input logic [63:0] act_val);
      if (act_val !== exp_val) begin
         $display("error at time %0t: %s expected %h got %h",
                  $time, name, exp_val, act_val);
         abort_run("value mismatch");
      end
   endtask

   // Cycle limit set once the stimulus is parsed
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
         abort_run("timeout: the run did not finish within the cycle limit");
   end

   // ----------------------------------------------------------------------
   // Stimulus file
   // ----------------------------------------------------------------------
   task automatic read_stim();
      fd = $fopen("verif/phold_stim.txt", "r");
      if (fd == 0)
         abort_run("could not open the stimulus file");
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         // Skip blanks and comment lines
         if (line.len() > 1 && line[0] != "#") begin
            arg_a = '0;
            arg_b = '0;
            rc = $sscanf(line.substr(1, line.len() - 1), "%h %h", arg_a, arg_b);
            op_q.push_back(line[0]);
            arg_a_q.push_back(arg_a);
            arg_b_q.push_back(arg_b);
            if (line[0] == "S")
               cycle_sum += int'(arg_a);
         end
      end
      $fclose(fd);
      cycle_limit = 50 * op_q.size() + cycle_sum;
   endtask

   // ----------------------------------------------------------------------
   // Dispatch and CSR requests, response sampled mid T+1
   // ----------------------------------------------------------------------
   task automatic aeg_write(input aeg_idx_t idx, input aeg_data_t data);
      @(posedge clk);
      disp_aeg_idx     <= idx;
      disp_aeg_wr_data <= data;
      disp_aeg_wr      <= 1'b1;
      @(posedge clk);
      disp_aeg_wr      <= 1'b0;
      @(negedge clk);
      last_exc = disp_exception;
   endtask

   task automatic aeg_read(input aeg_idx_t idx, input aeg_data_t exp_data);
      @(posedge clk);
      disp_aeg_idx <= idx;
      disp_aeg_rd  <= 1'b1;
      @(posedge clk);
      disp_aeg_rd  <= 1'b0;
      @(negedge clk);
      check("disp_rtn_data_vld", 64'd1, {63'd0, disp_rtn_data_vld});
      check("disp_rtn_data", exp_data, disp_rtn_data);
      last_exc = disp_exception;
   endtask

   task automatic csr_read(input logic [15:0] addr, input aeg_data_t exp_data);
      @(posedge clk);
      csr_address <= addr;
      csr_rd_vld  <= 1'b1;
      @(posedge clk);
      csr_rd_vld  <= 1'b0;
      @(negedge clk);
      check("csr_rd_ack", 64'd1, {63'd0, csr_rd_ack});
      check("csr_rd_data", exp_data, csr_rd_data);
   endtask

   task automatic issue_inst(input logic [4:0] inst);
      @(posedge clk);
      disp_inst     <= inst;
      disp_inst_vld <= 1'b1;
      @(posedge clk);
      disp_inst_vld <= 1'b0;
      @(negedge clk);
      last_exc = disp_exception;
   endtask

   // Start, retry the start while running, then wait for idle
   task automatic run_to_idle();
      issue_inst(5'd0);
      check("disp_stall", 64'd1, {63'd0, disp_stall});
      check("disp_idle", 64'd0, {63'd0, disp_idle});
      issue_inst(5'd0);
      check("run", 64'd1, {63'd0, DUT.u_dispatch.run});
      check("disp_exception", 64'd0, {48'd0, last_exc});
      while (!disp_idle) begin
         check("disp_stall", 64'd1, {63'd0, disp_stall});
         @(negedge clk);
      end
      // A latched second start would leave IDLE again
      @(negedge clk);
      check("disp_idle", 64'd1, {63'd0, disp_idle});
      check("disp_stall", 64'd0, {63'd0, disp_stall});
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      reset            = 1'b1;
      disp_inst_vld    = 1'b0;
      disp_inst        = '0;
      disp_aeg_idx     = '0;
      disp_aeg_rd      = 1'b0;
      disp_aeg_wr      = 1'b0;
      disp_aeg_wr_data = '0;
      csr_rd_vld       = 1'b0;
      csr_address      = '0;
      last_exc         = '0;
      read_stim();
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            "W": aeg_write(aeg_idx_t'(arg_a_q[i]), arg_b_q[i]);
            "R": aeg_read(aeg_idx_t'(arg_a_q[i]), arg_b_q[i]);
            "C": csr_read(arg_a_q[i][15:0], arg_b_q[i]);
            "I": issue_inst(arg_a_q[i][4:0]);
            "E": check("disp_exception", arg_a_q[i], {48'd0, last_exc});
            "S": run_to_idle();
            default: abort_run("unknown record type in the stimulus file");
         endcase
      end
      @(posedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
src/phold_pkg.sv
src/lp_event_core.sv
src/gvt_reduce.sv
src/pers_dispatch.sv
src/phold_pers_top.sv
verif/phold_pers_assertions.sv
verif/tb_phold_pers.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the PHOLD personality testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
   --top-module tb_phold_pers \
   -f verilog.f \
   -o Vtb_phold_pers

# Simulation output is searched for the pass line
sim_out=$(./obj_dir/Vtb_phold_pers 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
   exit 0
else
   exit 1
fi

//--- verif/phold_stim.txt
# Record: op arg_a arg_b, all values hex
# W idx data | R idx expected | C addr expected | I inst | E exception | S total_cycles
W 0 64
W 1 7
W 2 a
W 3 3
W 4 deadbeef0123
R 0 64
R 1 7
R 2 a
R 3 3
R 4 deadbeef0123
R 5 0
R 6 0
R 7 0
R 8 0
E 2
W 9 1234
E 2
I 3
E 1
C 0 0
S 10
R 5 64
R 6 10
R 7 19
C 1 64
C 0 0
W 3 2
S b
R 5 64
R 6 b
R 7 a
W 3 0
S 1
R 5 ffff
R 6 1
R 7 0
C 1 ffff
C 0 0
C 7 0
